/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ====================
    // core side opcodes
    // ====================

    // loads first, then stores
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    // ====================
    // bus phases
    // ====================

    // read channel, address then data
    typedef enum logic {
        rd_idle = 1'b0,
        rd_busy = 1'b1
    } rd_state_e;

    // write channel, address then data then response
    typedef enum logic [1:0] {
        wr_idle = 2'd0,
        wr_data = 2'd1,
        wr_resp = 2'd2
    } wr_state_e;

    // remembered pc after reset, never a real instruction address
    localparam logic [31:0] pc_rst = 32'h8000_0000;

endpackage

`default_nettype wire

/* logic/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align import mem_pkg::*; (
    input  wire mem_op_e op,
    input  wire  [1:0]  byte_offset,
    input  wire  [31:0] bus_data,
    output logic [31:0] rdata
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // lane pick, halfword uses only the upper offset bit
    assign sel_byte = bus_data[{byte_offset, 3'b000} +: 8];
    assign sel_half = byte_offset[1] ? bus_data[31:16] : bus_data[15:0];

    always_comb begin
        case (op)
            op_lb: begin
                rdata = {{24{sel_byte[7]}}, sel_byte};
            end
            op_lbu: begin
                rdata = {24'h00_0000, sel_byte};
            end
            op_lh: begin
                rdata = {{16{sel_half[15]}}, sel_half};
            end
            op_lhu: begin
                rdata = {16'h0000, sel_half};
            end
            op_lw: begin
                rdata = bus_data;
            end
            // stores give nothing back
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram import mem_pkg::*; #(
    parameter int sram_latency = 2,
    parameter int sram_words   = 256
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    input  wire         rready,
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wvalid,
    input  wire         bready,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        bus_rvalid,
    output logic        awready,
    output logic        bus_wready,
    output logic        bvalid
);

    // depth is a power of two, so the slice wraps the address
    localparam int idx_w = $clog2(sram_words);
    localparam int cnt_w = $clog2(sram_latency + 1);
    localparam logic [cnt_w-1:0] lat_init = cnt_w'(sram_latency - 1);

    logic [31:0]      mem [sram_words];
    logic [idx_w-1:0] rd_idx_q;
    logic [idx_w-1:0] wr_idx_q;
    logic [cnt_w-1:0] rd_cnt;
    logic [cnt_w-1:0] wr_cnt;
    rd_state_e        rd_state;
    wr_state_e        wr_state;

    // ====================
    // read side
    // ====================

    assign arready    = (rd_state == rd_idle);
    assign bus_rvalid = (rd_state == rd_busy) && (rd_cnt == '0);
    assign rdata      = mem[rd_idx_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= rd_idle;
            rd_cnt   <= '0;
        end else if (rd_state == rd_idle) begin
            if (arvalid) begin
                rd_state <= rd_busy;
                rd_cnt   <= lat_init;
            end
        end else if (rd_cnt != '0) begin
            rd_cnt <= rd_cnt - cnt_w'(1);
        end else if (rready) begin
            rd_state <= rd_idle;
        end
    end

    // ====================
    // write side
    // ====================

    assign awready    = (wr_state == wr_idle);
    assign bus_wready = (wr_state == wr_data) && (wr_cnt == '0);
    assign bvalid     = (wr_state == wr_resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (awvalid) begin
                        wr_state <= wr_data;
                        wr_cnt   <= lat_init;
                    end
                end
                wr_data: begin
                    if (wr_cnt != '0) begin
                        wr_cnt <= wr_cnt - cnt_w'(1);
                    end else if (wvalid) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bready) begin
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // address latches and the array itself
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_idx_q <= araddr[idx_w+1:2];
        end
        if (awvalid && awready) begin
            wr_idx_q <= awaddr[idx_w+1:2];
        end
        if (wvalid && bus_wready) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx_q][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access import mem_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] pc,
    input  wire mem_op_e op,
    input  wire         mem_re,
    input  wire         mem_we,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    input  wire         arready,
    input  wire         bus_rvalid,
    input  wire         awready,
    input  wire         bus_wready,
    input  wire         bvalid,
    output logic [31:0] araddr,
    output logic        arvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic        awvalid,
    output logic [31:0] wdata_lane,
    output logic [3:0]  wstrb,
    output logic        wvalid,
    output logic        bready,
    output logic        rvalid,
    output logic        wready
);

    logic [31:0] pc_r_q;
    logic [31:0] pc_w_q;
    logic        pc_change_r;
    logic        pc_change_w;
    rd_state_e   rd_state;
    wr_state_e   wr_state;
    logic [3:0]  strb_base;

    // a request only counts once per instruction
    assign pc_change_r = mem_re && (pc != pc_r_q);
    assign pc_change_w = mem_we && (pc != pc_w_q);

    // ====================
    // read master
    // ====================

    assign araddr  = addr;
    assign arvalid = (rd_state == rd_idle) && pc_change_r;
    assign rready  = (rd_state == rd_busy);
    assign rvalid  = (rd_state == rd_idle) && !pc_change_r;

    // pc is taken on the address handshake so arvalid holds until then
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= rd_idle;
            pc_r_q   <= pc_rst;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (arvalid && arready) begin
                        rd_state <= rd_busy;
                        pc_r_q   <= pc;
                    end
                end
                rd_busy: begin
                    if (bus_rvalid && rready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // ====================
    // write master
    // ====================

    assign awaddr  = addr;
    assign awvalid = (wr_state == wr_idle) && pc_change_w;
    assign wvalid  = (wr_state == wr_data);
    assign bready  = (wr_state == wr_resp);
    assign wready  = (wr_state == wr_idle) && !pc_change_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
            pc_w_q   <= pc_rst;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (awvalid && awready) begin
                        wr_state <= wr_data;
                        pc_w_q   <= pc;
                    end
                end
                wr_data: begin
                    if (wvalid && bus_wready) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bvalid && bready) begin
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // store lanes, data and strobe move by the byte offset
    always_comb begin
        case (op)
            op_sb:   strb_base = 4'b0001;
            op_sh:   strb_base = 4'b0011;
            op_sw:   strb_base = 4'b1111;
            default: strb_base = 4'b0000;
        endcase
    end

    assign wstrb      = strb_base << addr[1:0];
    assign wdata_lane = wdata << {addr[1:0], 3'b000};

endmodule

`default_nettype wire

/* logic/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top import mem_pkg::*; #(
    parameter int sram_latency = 2,
    parameter int sram_words   = 256
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] pc,
    input  wire mem_op_e op,
    input  wire         mem_re,
    input  wire         mem_we,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        wready
);

    // ====================
    // bus wires
    // ====================

    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] bus_rdata;
    logic        bus_rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata_lane;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bus_wready;
    logic        bvalid;
    logic        bready;

    mem_access u_access (
        .clk(clk), .rst(rst), .pc(pc), .op(op),
        .mem_re(mem_re), .mem_we(mem_we), .addr(addr), .wdata(wdata),
        .arready(arready), .bus_rvalid(bus_rvalid), .awready(awready),
        .bus_wready(bus_wready), .bvalid(bvalid),
        .araddr(araddr), .arvalid(arvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .wdata_lane(wdata_lane),
        .wstrb(wstrb), .wvalid(wvalid), .bready(bready),
        .rvalid(rvalid), .wready(wready)
    );

    data_sram #(
        .sram_latency(sram_latency),
        .sram_words  (sram_words)
    ) u_sram (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid),
        .wdata(wdata_lane), .wstrb(wstrb), .wvalid(wvalid), .bready(bready),
        .arready(arready), .rdata(bus_rdata), .bus_rvalid(bus_rvalid),
        .awready(awready), .bus_wready(bus_wready), .bvalid(bvalid)
    );

    // core holds op and addr until rvalid, so the offset is stable
    load_align u_align (
        .op         (op),
        .byte_offset(addr[1:0]),
        .bus_data   (bus_rdata),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb import mem_pkg::*;;

    localparam int sram_latency   = 3;
    // accesses over all tests with the repeated pc hold counted as one
    localparam int access_count   = 165;
    localparam int timeout_cycles = 8 * access_count * (sram_latency + 4);

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    mem_op_e     op;
    logic        mem_re;
    logic        mem_we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;
    logic        wready;

    logic [7:0]  model [1024];
    logic [31:0] pool [16];
    logic [31:0] pc_next = 32'h1000;
    int          error_count = 0;
    int          cycle_count = 0;

    clock_gen u_clk (.clk(clk), .rst(rst));

    mem_stage_top #(
        .sram_latency(sram_latency),
        .sram_words  (256)
    ) uut (
        .clk(clk), .rst(rst), .pc(pc), .op(op),
        .mem_re(mem_re), .mem_we(mem_we), .addr(addr), .wdata(wdata),
        .rdata(rdata), .rvalid(rvalid), .wready(wready)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // ====================
    // reference model
    // ====================

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %08h actual %08h", $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // stores write from the addressed byte upwards
    function automatic void model_store(input mem_op_e kind, input logic [31:0] a,
                                        input logic [31:0] d);
        logic [9:0] i;
        i = a[9:0];
        model[i] = d[7:0];
        if (kind != op_sb) begin
            model[i + 10'd1] = d[15:8];
        end
        if (kind == op_sw) begin
            model[i + 10'd2] = d[23:16];
            model[i + 10'd3] = d[31:24];
        end
    endfunction

    function automatic logic [31:0] model_load(input mem_op_e kind, input logic [31:0] a);
        logic [9:0]  i;
        logic [7:0]  b0;
        logic [15:0] h0;
        i  = a[9:0];
        b0 = model[i];
        h0 = {model[i + 10'd1], model[i]};
        case (kind)
            op_lb:   model_load = {{24{b0[7]}}, b0};
            op_lbu:  model_load = {24'd0, b0};
            op_lh:   model_load = {{16{h0[15]}}, h0};
            op_lhu:  model_load = {16'd0, h0};
            op_lw:   model_load = {model[i + 10'd3], model[i + 10'd2], h0};
            default: model_load = 32'd0;
        endcase
    endfunction

    // ====================
    // bus access tasks
    // ====================

    task automatic do_store(input mem_op_e kind, input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        pc      = pc_next;
        pc_next = pc_next + 32'd4;
        op      = kind;
        addr    = a;
        wdata   = d;
        mem_re  = 1'b0;
        mem_we  = 1'b1;
        @(negedge clk);
        compare_value("wready", 32'd0, {31'd0, wready});
        while (!wready) begin
            @(negedge clk);
        end
        model_store(kind, a, d);
        @(posedge clk);
        #1;
        mem_we = 1'b0;
    endtask

    task automatic do_load(input mem_op_e kind, input logic [31:0] a);
        logic [31:0] got;
        @(posedge clk);
        #1;
        pc      = pc_next;
        pc_next = pc_next + 32'd4;
        op      = kind;
        addr    = a;
        mem_re  = 1'b1;
        mem_we  = 1'b0;
        @(negedge clk);
        compare_value("rvalid", 32'd0, {31'd0, rvalid});
        while (!rvalid) begin
            @(negedge clk);
        end
        // op and addr still held, so rdata is the formatted load
        got = rdata;
        @(posedge clk);
        #1;
        mem_re = 1'b0;
        compare_value("rdata", model_load(kind, a), got);
    endtask

    // ====================
    // directed tests
    // ====================

    task automatic test_reset_state();
        repeat (3) begin
            @(negedge clk);
            compare_value("rvalid", 32'd1, {31'd0, rvalid});
            compare_value("wready", 32'd1, {31'd0, wready});
        end
        wait (rst == 1'b0);
        repeat (2) begin
            @(negedge clk);
            compare_value("rvalid", 32'd1, {31'd0, rvalid});
            compare_value("wready", 32'd1, {31'd0, wready});
        end
    endtask

    task automatic test_word_round_trip();
        for (int n = 0; n < 16; n++) begin
            pool[n] = {22'd0, 8'($urandom), 2'b00};
            do_store(op_sw, pool[n], $urandom);
        end
        for (int n = 0; n < 16; n++) begin
            do_load(op_lw, pool[n]);
        end
    endtask

    task automatic test_partial_store();
        logic [31:0] base;
        for (int w = 0; w < 4; w++) begin
            base = {22'd0, 8'(200 + w), 2'b00};
            do_store(op_sw, base, $urandom);
            for (int o = 0; o < 4; o++) begin
                do_store(op_sb, base + 32'(o), $urandom);
                do_load(op_lw, base);
            end
            for (int o = 0; o < 4; o += 2) begin
                do_store(op_sh, base + 32'(o), $urandom);
                do_load(op_lw, base);
            end
        end
    endtask

    task automatic test_load_extension();
        logic [31:0] base;
        logic [31:0] pattern [4];
        // sign bits set and clear in every byte and halfword lane
        pattern[0] = 32'h807f_ff01;
        pattern[1] = 32'h7f80_01ff;
        pattern[2] = $urandom;
        pattern[3] = $urandom;
        for (int w = 0; w < 4; w++) begin
            base = {22'd0, 8'(210 + w), 2'b00};
            do_store(op_sw, base, pattern[w]);
            for (int o = 0; o < 4; o++) begin
                do_load(op_lb, base + 32'(o));
                do_load(op_lbu, base + 32'(o));
            end
            for (int o = 0; o < 4; o += 2) begin
                do_load(op_lh, base + 32'(o));
                do_load(op_lhu, base + 32'(o));
            end
        end
    endtask

    task automatic test_repeated_pc();
        logic [31:0] a;
        logic [31:0] first;
        a     = pool[3];
        first = $urandom;
        do_store(op_sw, a, first);
        // same pc again, different data
        @(posedge clk);
        #1;
        op     = op_sw;
        addr   = a;
        wdata  = ~first;
        mem_we = 1'b1;
        repeat (sram_latency + 4) begin
            @(negedge clk);
            compare_value("wready", 32'd1, {31'd0, wready});
        end
        @(posedge clk);
        #1;
        mem_we = 1'b0;
        do_load(op_lw, a);
        do_store(op_sw, a, ~first);
        do_load(op_lw, a);
    endtask

    task automatic test_interleaved();
        logic [31:0] a;
        int          kind;
        for (int n = 0; n < 12; n++) begin
            a    = pool[4'($urandom)];
            kind = int'($urandom % 3);
            case (kind)
                0:       do_store(op_sb, a + {30'd0, 2'($urandom)}, $urandom);
                1:       do_store(op_sh, a + {30'd0, 1'($urandom), 1'b0}, $urandom);
                default: do_store(op_sw, a, $urandom);
            endcase
            a    = pool[4'($urandom)];
            kind = int'($urandom % 5);
            case (kind)
                0:       do_load(op_lb, a + {30'd0, 2'($urandom)});
                1:       do_load(op_lbu, a + {30'd0, 2'($urandom)});
                2:       do_load(op_lh, a + {30'd0, 1'($urandom), 1'b0});
                3:       do_load(op_lhu, a + {30'd0, 1'($urandom), 1'b0});
                default: do_load(op_lw, a);
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'h6e96_88b0));
        pc     = pc_rst;
        op     = op_lw;
        mem_re = 1'b0;
        mem_we = 1'b0;
        addr   = 32'd0;
        wdata  = 32'd0;
        test_reset_state();
        test_word_round_trip();
        test_partial_store();
        test_load_extension();
        test_repeated_pc();
        test_interleaved();
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/mem_pkg.sv
logic/load_align.sv
logic/data_sram.sv
logic/mem_access.sv
logic/mem_stage_top.sv
testbench/clock_gen.sv
testbench/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module mem_stage_tb -o mem_stage_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
